// File: rtl/gray_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module gray_accel_top
    import gray_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       csr_wr_en,
    input  t_csr_addr  csr_wr_addr,
    input  t_csr_data  csr_wr_data,
    input  t_csr_addr  csr_rd_addr,
    output t_csr_data  csr_rd_data,
    output logic       rd_req_valid,
    output t_line_addr rd_req_addr,
    output t_line_tag  rd_req_tag,
    input  logic       rd_req_almost_full,
    input  logic       rd_rsp_valid,
    input  t_line_tag  rd_rsp_tag,
    input  t_line_data rd_rsp_data,
    output logic       wr_req_valid,
    output t_line_addr wr_req_addr,
    output t_line_data wr_req_data,
    input  logic       wr_req_almost_full,
    input  logic       wr_rsp_valid
);

    logic         run;
    logic         report;
    t_line_addr   src_addr;
    t_line_addr   dst_addr;
    t_line_addr   status_addr;
    t_count       num_lines;
    t_count       read_idx;
    logic         read_done;
    t_count       write_req_cnt;
    t_count       write_resp_cnt;
    t_cycle_count clk_cnt;
    logic         fifo_almost_full;
    logic         gray_valid;
    t_line_data   gray_data;

    gray_job_ctrl u_gray_job_ctrl
    (
        .clk,
        .reset,
        .csr_wr_en,
        .csr_wr_addr,
        .csr_wr_data,
        .csr_rd_addr,
        .csr_rd_data,
        .wr_rsp_valid,
        .read_idx,
        .read_done,
        .write_req_cnt,
        .run,
        .report,
        .src_addr,
        .dst_addr,
        .status_addr,
        .num_lines,
        .clk_cnt,
        .write_resp_cnt
    );

    gray_read_engine u_gray_read_engine
    (
        .clk,
        .reset,
        .run,
        .src_addr,
        .num_lines,
        .rd_req_almost_full,
        .wr_req_almost_full,
        .fifo_almost_full,
        .wr_rsp_valid,
        .rd_req_valid,
        .rd_req_addr,
        .rd_req_tag,
        .read_idx,
        .read_done
    );

    gray_pixel_core u_gray_pixel_core
    (
        .clk,
        .reset,
        .valid_in  (rd_rsp_valid),
        .data_in   (rd_rsp_data),
        .valid_out (gray_valid),
        .data_out  (gray_data)
    );

    gray_write_engine u_gray_write_engine
    (
        .clk,
        .reset,
        .gray_valid,
        .gray_data,
        .rd_rsp_tag,
        .rd_rsp_valid,
        .dst_addr,
        .status_addr,
        .report,
        .read_idx,
        .write_resp_cnt,
        .clk_cnt,
        .wr_req_almost_full,
        .wr_req_valid,
        .wr_req_addr,
        .wr_req_data,
        .fifo_almost_full,
        .write_req_cnt
    );

endmodule

`default_nettype wire

// File: rtl/gray_job_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gray_job_ctrl
    import gray_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         csr_wr_en,
    input  t_csr_addr    csr_wr_addr,
    input  t_csr_data    csr_wr_data,
    input  t_csr_addr    csr_rd_addr,
    output t_csr_data    csr_rd_data,
    input  logic         wr_rsp_valid,
    input  t_count       read_idx,
    input  logic         read_done,
    input  t_count       write_req_cnt,
    output logic         run,
    output logic         report,
    output t_line_addr   src_addr,
    output t_line_addr   dst_addr,
    output t_line_addr   status_addr,
    output t_count       num_lines,
    output t_cycle_count clk_cnt,
    output t_count       write_resp_cnt
);

    t_ctrl_state state;
    logic        start_ok;
    logic        start_q;

    // ======================================================================
    // CSR registers
    // ======================================================================

    // a start is only taken once the job is fully programmed
    assign start_ok = csr_wr_en && (csr_wr_addr == CSR_CTL) && csr_wr_data[0] &&
                      (src_addr != '0) && (dst_addr != '0) && (num_lines != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            status_addr <= '0;
            src_addr    <= '0;
            dst_addr    <= '0;
            num_lines   <= '0;
            start_q     <= 1'b0;
        end
        else
        begin
            start_q <= start_ok;
            if (csr_wr_en)
            begin
                case (csr_wr_addr)
                    CSR_STATUS_ADDR: status_addr <= t_line_addr'(csr_wr_data);
                    CSR_SRC_ADDR:    src_addr    <= t_line_addr'(csr_wr_data);
                    CSR_DST_ADDR:    dst_addr    <= t_line_addr'(csr_wr_data);
                    CSR_NUM_LINES:   num_lines   <= t_count'(csr_wr_data);
                    default:         ;
                endcase
            end
        end
    end

    // ======================================================================
    // control FSM and counters
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state          <= CTRL_IDLE;
            clk_cnt        <= '0;
            write_resp_cnt <= '0;
        end
        else
        begin
            case (state)
                CTRL_IDLE:
                begin
                    if (start_q)
                    begin
                        state          <= CTRL_RUN;
                        clk_cnt        <= '0;
                        write_resp_cnt <= '0;
                    end
                end
                CTRL_RUN:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (wr_rsp_valid)
                        write_resp_cnt <= write_resp_cnt + 1'b1;
                    // every line read and every data write acknowledged
                    if (read_done && (write_resp_cnt == num_lines))
                        state <= CTRL_REPORT;
                end
                default:
                    state <= CTRL_IDLE;
            endcase
        end
    end

    assign run    = (state == CTRL_RUN);
    assign report = (state == CTRL_REPORT);

    // read side, unmapped and write-only indices give zero
    always_comb
    begin
        case (csr_rd_addr)
            CSR_STATUS_ADDR:    csr_rd_data = t_csr_data'(status_addr);
            CSR_SRC_ADDR:       csr_rd_data = t_csr_data'(src_addr);
            CSR_DST_ADDR:       csr_rd_data = t_csr_data'(dst_addr);
            CSR_NUM_LINES:      csr_rd_data = t_csr_data'(num_lines);
            CSR_READ_IDX:       csr_rd_data = t_csr_data'(read_idx);
            CSR_WRITE_REQ_CNT:  csr_rd_data = t_csr_data'(write_req_cnt);
            CSR_WRITE_RESP_CNT: csr_rd_data = t_csr_data'(write_resp_cnt);
            CSR_STATE:          csr_rd_data = t_csr_data'(state);
            CSR_CLK_CNT:        csr_rd_data = clk_cnt;
            default:            csr_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/gray_pixel_core.sv
`timescale 1ns/1ps
`default_nettype none

module gray_pixel_core
    import gray_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       valid_in,
    input  t_line_data data_in,
    output logic       valid_out,
    output t_line_data data_out
);

    // weighted sum fits in 16 bits, the upper byte is the gray level
    function automatic logic [7:0] luma(input logic [31:0] pixel);
        logic [15:0] sum;
        sum = 16'(LUMA_R * pixel[7:0] + LUMA_G * pixel[15:8] + LUMA_B * pixel[23:16]);
        return sum[15:8];
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    // alpha is kept, r g b all take the gray level
    always_ff @(posedge clk)
    begin
        if (valid_in)
        begin
            for (int i = 0; i < PIXELS_PER_LINE; i++)
            begin
                data_out[32*i +: 32] <= {data_in[32*i+24 +: 8],
                                         {3{luma(data_in[32*i +: 32])}}};
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/gray_pkg.sv
`default_nettype none

package gray_pkg;

    // ======================================================================
    // widths that carry a meaning
    // ======================================================================

    typedef logic [31:0]  t_line_addr;
    // four pixels, r in 7:0, g in 15:8, b in 23:16, a in 31:24
    typedef logic [127:0] t_line_data;
    // the tag is the line index, so a job is limited to 65535 lines
    typedef logic [15:0]  t_line_tag;
    typedef logic [31:0]  t_count;
    typedef logic [63:0]  t_cycle_count;
    typedef logic [3:0]   t_csr_addr;
    typedef logic [63:0]  t_csr_data;

    typedef enum logic [1:0]
    {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_REPORT
    } t_ctrl_state;

    // ======================================================================
    // CSR map
    // ======================================================================

    localparam t_csr_addr CSR_STATUS_ADDR    = 4'd0;
    localparam t_csr_addr CSR_SRC_ADDR       = 4'd1;
    localparam t_csr_addr CSR_DST_ADDR       = 4'd2;
    localparam t_csr_addr CSR_NUM_LINES      = 4'd3;
    localparam t_csr_addr CSR_READ_IDX       = 4'd4;
    localparam t_csr_addr CSR_WRITE_REQ_CNT  = 4'd5;
    localparam t_csr_addr CSR_WRITE_RESP_CNT = 4'd6;
    localparam t_csr_addr CSR_STATE          = 4'd7;
    localparam t_csr_addr CSR_CLK_CNT        = 4'd8;
    // write only, reads back as zero
    localparam t_csr_addr CSR_CTL            = 4'd10;

    // ======================================================================
    // limits
    // ======================================================================

    // reads issued whose write responses are still out
    localparam int MAX_OUTSTANDING   = 62;
    localparam int WFIFO_DEPTH       = 16;
    localparam int WFIFO_ALMOST_FULL = 12;
    localparam int PIXELS_PER_LINE   = 4;

    // luma weights, gray is the weighted sum shifted right by 8
    localparam int LUMA_R = 77;
    localparam int LUMA_G = 150;
    localparam int LUMA_B = 29;

endpackage

`default_nettype wire

// File: rtl/gray_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module gray_read_engine
    import gray_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  t_line_addr src_addr,
    input  t_count     num_lines,
    input  logic       rd_req_almost_full,
    input  logic       wr_req_almost_full,
    input  logic       fifo_almost_full,
    input  logic       wr_rsp_valid,
    output logic       rd_req_valid,
    output t_line_addr rd_req_addr,
    output t_line_tag  rd_req_tag,
    output t_count     read_idx,
    output logic       read_done
);

    logic   run_q;
    logic   run_rise;
    logic   can_read;
    logic   stage2;
    logic   stall;
    logic   issue;
    logic   advance;
    t_count line_q;
    t_count outstanding;
    t_count outstanding_next;

    assign run_rise  = run && !run_q;
    assign read_done = (read_idx == num_lines);

    // stage two waits while the host read channel is almost full
    assign stall   = stage2 && rd_req_almost_full;
    assign issue   = stage2 && !rd_req_almost_full;
    assign advance = can_read && !read_done && !stall;

    // balance counts a read as soon as its index is taken
    always_comb
    begin
        outstanding_next = outstanding;
        if (advance)
            outstanding_next = outstanding_next + 1'b1;
        if (wr_rsp_valid && (outstanding_next != '0))
            outstanding_next = outstanding_next - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_q        <= 1'b0;
            can_read     <= 1'b0;
            stage2       <= 1'b0;
            rd_req_valid <= 1'b0;
            read_idx     <= '0;
            outstanding  <= '0;
        end
        else
        begin
            run_q        <= run;
            can_read     <= run && !rd_req_almost_full && !wr_req_almost_full &&
                            !fifo_almost_full && (outstanding_next < MAX_OUTSTANDING);
            rd_req_valid <= issue;
            if (run_rise)
            begin
                read_idx    <= '0;
                outstanding <= '0;
            end
            else
            begin
                outstanding <= outstanding_next;
                if (advance)
                    read_idx <= read_idx + 1'b1;
            end
            if (advance)
                stage2 <= 1'b1;
            else if (issue)
                stage2 <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            line_q <= read_idx;
        if (issue)
        begin
            rd_req_addr <= src_addr + line_q;
            rd_req_tag  <= t_line_tag'(line_q);
        end
    end

endmodule

`default_nettype wire

// File: rtl/gray_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module gray_write_engine
    import gray_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         gray_valid,
    input  t_line_data   gray_data,
    input  t_line_tag    rd_rsp_tag,
    input  logic         rd_rsp_valid,
    input  t_line_addr   dst_addr,
    input  t_line_addr   status_addr,
    input  logic         report,
    input  t_count       read_idx,
    input  t_count       write_resp_cnt,
    input  t_cycle_count clk_cnt,
    input  logic         wr_req_almost_full,
    output logic         wr_req_valid,
    output t_line_addr   wr_req_addr,
    output t_line_data   wr_req_data,
    output logic         fifo_almost_full,
    output t_count       write_req_cnt
);

    t_line_addr data_addr_q;
    t_line_addr push_addr;
    t_line_addr head_addr;
    t_line_data push_data;
    t_line_data head_data;
    t_line_data status_line;
    logic       push;
    logic       pop;
    logic       not_empty;
    logic       cnt_restart;

    always_comb
    begin
        status_line         = '0;
        status_line[0]      = 1'b1;
        status_line[63:32]  = read_idx;
        status_line[95:64]  = write_resp_cnt;
        status_line[127:96] = clk_cnt[31:0];
    end

    // data and status never collide, report comes after the last response
    assign push      = gray_valid || report;
    assign push_addr = gray_valid ? data_addr_q : status_addr;
    assign push_data = gray_valid ? gray_data : status_line;
    assign pop       = not_empty && !wr_req_almost_full;

    // same cycle as the pixel core so the address lines up with gray_valid
    always_ff @(posedge clk)
    begin
        if (rd_rsp_valid)
            data_addr_q <= dst_addr + t_line_addr'(rd_rsp_tag);
    end

    gray_write_fifo u_gray_write_fifo
    (
        .clk,
        .reset,
        .push,
        .push_addr,
        .push_data,
        .pop,
        .head_addr,
        .head_data,
        .not_empty,
        .almost_full (fifo_almost_full)
    );

    // the count holds after a job and restarts at the next data write
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_req_valid  <= 1'b0;
            write_req_cnt <= '0;
            cnt_restart   <= 1'b0;
        end
        else
        begin
            wr_req_valid <= pop;
            if (gray_valid)
            begin
                write_req_cnt <= cnt_restart ? t_count'(1) : write_req_cnt + 1'b1;
                cnt_restart   <= 1'b0;
            end
            else if (report)
                cnt_restart <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            wr_req_addr <= head_addr;
            wr_req_data <= head_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/gray_write_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module gray_write_fifo
    import gray_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  t_line_addr push_addr,
    input  t_line_data push_data,
    input  logic       pop,
    output t_line_addr head_addr,
    output t_line_data head_data,
    output logic       not_empty,
    output logic       almost_full
);

    t_line_addr                     addr_mem [WFIFO_DEPTH];
    t_line_data                     data_mem [WFIFO_DEPTH];
    logic [$clog2(WFIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(WFIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(WFIFO_DEPTH):0]   count;
    logic                           do_push;
    logic                           do_pop;

    // a push into a full buffer is dropped
    assign do_push     = push && (count != WFIFO_DEPTH);
    assign do_pop      = pop && not_empty;
    assign not_empty   = (count != '0);
    assign almost_full = (count >= WFIFO_ALMOST_FULL);

    // show-ahead, the head is visible before the pop
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module gray_accel_tb --Mdir obj_dir -o gray_accel_sim &&
{ ./obj_dir/gray_accel_sim 2>&1 | tee sim.log; } &&
grep -qx "Test passed" sim.log &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }

// File: sources.f
+incdir+include
rtl/gray_pkg.sv
rtl/gray_job_ctrl.sv
rtl/gray_read_engine.sv
rtl/gray_pixel_core.sv
rtl/gray_write_fifo.sv
rtl/gray_write_engine.sv
rtl/gray_accel_top.sv
verification/gray_accel_tb.sv

// File: include/gray_tb_model.svh
`ifndef GRAY_TB_MODEL_SVH
`define GRAY_TB_MODEL_SVH

// host memory keyed by line address
t_line_data  src_mem [t_line_addr];
t_line_data  dst_mem [t_line_addr];
int          wr_hits [t_line_addr];

// reads waiting for a response, write responses waiting for their cycle
t_line_addr  pend_addr [$];
t_line_tag   pend_tag [$];
longint      wr_rsp_due [$];
longint      model_cyc = 0;

logic [31:0] lfsr_state = 32'hc544_73d1;
int          rd_af_held = 0;
int          wr_af_held = 0;
int          model_outstanding = 0;

// fibonacci form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++)
    begin
        lfsr_state = lfsr_next(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

function automatic t_line_data ref_gray(input t_line_data line);
    t_line_data result;
    int         y;
    for (int i = 0; i < PIXELS_PER_LINE; i++)
    begin
        y = (LUMA_R * line[32*i +: 8] + LUMA_G * line[32*i+8 +: 8] +
             LUMA_B * line[32*i+16 +: 8]) >> 8;
        result[32*i +: 32] = {line[32*i+24 +: 8], {3{y[7:0]}}};
    end
    return result;
endfunction

task automatic fill_source(input t_line_addr base, input int lines);
    t_line_data line;
    for (int n = 0; n < lines; n++)
    begin
        for (int w = 0; w < PIXELS_PER_LINE; w++)
            line[32*w +: 32] = random_bits(32);
        src_mem[base + t_line_addr'(n)] = line;
    end
endtask

// one host cycle, called just after each rising edge
task automatic model_cycle();
    int pick;
    model_cyc++;
    // a level held for two cycles must have stopped the request
    check_value("read almost-full obeyed", 128'(0),
                128'(rd_req_valid && (rd_af_held >= 2)));
    check_value("write almost-full obeyed", 128'(0),
                128'(wr_req_valid && (wr_af_held >= 2)));
    if (rd_req_valid)
    begin
        pend_addr.push_back(rd_req_addr);
        pend_tag.push_back(rd_req_tag);
        model_outstanding++;
        check_value("outstanding limit", 128'(1),
                    128'(model_outstanding <= MAX_OUTSTANDING));
    end
    if (wr_req_valid)
    begin
        dst_mem[wr_req_addr] = wr_req_data;
        wr_hits[wr_req_addr] = wr_hits.exists(wr_req_addr) ? wr_hits[wr_req_addr] + 1 : 1;
        wr_rsp_due.push_back(model_cyc + 1 + longint'(random_bits(4)) % 12);
    end
    // a random pending read answers, so responses come out of order
    rd_rsp_valid = 1'b0;
    if ((pend_tag.size() != 0) && (random_bits(2) == 32'd0))
    begin
        pick = int'(random_bits(8)) % pend_tag.size();
        rd_rsp_valid = 1'b1;
        rd_rsp_tag   = pend_tag[pick];
        rd_rsp_data  = src_mem[pend_addr[pick]];
        pend_tag.delete(pick);
        pend_addr.delete(pick);
    end
    wr_rsp_valid = 1'b0;
    if ((wr_rsp_due.size() != 0) && (wr_rsp_due[0] <= model_cyc))
    begin
        void'(wr_rsp_due.pop_front());
        wr_rsp_valid = 1'b1;
        if (model_outstanding > 0)
            model_outstanding--;
    end
    rd_req_almost_full = (random_bits(4) < 5) || (pend_tag.size() >= 8);
    wr_req_almost_full = (random_bits(4) < 5);
    rd_af_held = rd_req_almost_full ? rd_af_held + 1 : 0;
    wr_af_held = wr_req_almost_full ? wr_af_held + 1 : 0;
endtask

`endif

// File: verification/gray_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gray_accel_tb
    import gray_pkg::*;
;

    logic       clk;
    logic       reset;
    logic       csr_wr_en;
    t_csr_addr  csr_wr_addr;
    t_csr_data  csr_wr_data;
    t_csr_addr  csr_rd_addr;
    t_csr_data  csr_rd_data;
    logic       rd_req_valid;
    t_line_addr rd_req_addr;
    t_line_tag  rd_req_tag;
    logic       rd_req_almost_full;
    logic       rd_rsp_valid;
    t_line_tag  rd_rsp_tag;
    t_line_data rd_rsp_data;
    logic       wr_req_valid;
    t_line_addr wr_req_addr;
    t_line_data wr_req_data;
    logic       wr_req_almost_full;
    logic       wr_rsp_valid;

    `include "gray_tb_model.svh"

    gray_accel_top u_gray_accel_top
    (
        .clk,
        .reset,
        .csr_wr_en,
        .csr_wr_addr,
        .csr_wr_data,
        .csr_rd_addr,
        .csr_rd_data,
        .rd_req_valid,
        .rd_req_addr,
        .rd_req_tag,
        .rd_req_almost_full,
        .rd_rsp_valid,
        .rd_rsp_tag,
        .rd_rsp_data,
        .wr_req_valid,
        .wr_req_addr,
        .wr_req_data,
        .wr_req_almost_full,
        .wr_rsp_valid
    );

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic csr_write(input t_csr_addr addr, input t_csr_data data);
        @(posedge clk);
        #1;
        csr_wr_en   = 1'b1;
        csr_wr_addr = addr;
        csr_wr_data = data;
        @(posedge clk);
        #1;
        csr_wr_en   = 1'b0;
    endtask

    // read path is combinational, give it a moment to settle
    task automatic csr_read(input t_csr_addr addr, output t_csr_data value);
        csr_rd_addr = addr;
        #1;
        value = csr_rd_data;
    endtask

    task automatic run_job(input string name, input t_line_addr src, input t_line_addr dst,
                           input t_line_addr status, input int lines);
        t_csr_data  rd_val;
        t_line_data status_line;
        int         wait_cnt;
        int         lines_seen;
        logic       in_region;
        fill_source(src, lines);
        dst_mem.delete();
        wr_hits.delete();
        csr_write(CSR_SRC_ADDR, t_csr_data'(src));
        csr_write(CSR_DST_ADDR, t_csr_data'(dst));
        csr_write(CSR_STATUS_ADDR, t_csr_data'(status));
        csr_write(CSR_NUM_LINES, t_csr_data'(lines));
        csr_write(CSR_CTL, 64'd1);

        // the status write marks the end of the job at the ports
        wait_cnt = 0;
        while (!wr_hits.exists(status))
        begin
            @(posedge clk);
            #2;
            wait_cnt++;
            if (wait_cnt > 50000)
                fail_now({name, ": timeout waiting for the status write"});
        end
        lines_seen = 0;
        for (int n = 0; n < lines; n++)
        begin
            if (dst_mem.exists(dst + t_line_addr'(n)))
                lines_seen++;
        end
        check_value({name, " data lines before status"}, 128'(lines), 128'(lines_seen));

        wait_cnt = 0;
        csr_read(CSR_STATE, rd_val);
        while (rd_val != t_csr_data'(CTRL_IDLE))
        begin
            @(posedge clk);
            #2;
            wait_cnt++;
            if (wait_cnt > 100)
                fail_now({name, ": job control never returned to idle"});
            csr_read(CSR_STATE, rd_val);
        end

        // let the host model drain so nothing leaks into the next job
        wait_cnt = 0;
        while ((wr_rsp_due.size() != 0) || (pend_tag.size() != 0))
        begin
            @(posedge clk);
            #2;
            wait_cnt++;
            if (wait_cnt > 1000)
                fail_now({name, ": host model still has traffic pending"});
        end

        for (int n = 0; n < lines; n++)
        begin
            check_value({name, " gray line"}, ref_gray(src_mem[src + t_line_addr'(n)]),
                        dst_mem[dst + t_line_addr'(n)]);
        end
        foreach (wr_hits[addr])
        begin
            in_region = (addr == status) ||
                        ((addr >= dst) && (addr < dst + t_line_addr'(lines)));
            check_value({name, " write inside regions"}, 128'(1), 128'(in_region));
            check_value({name, " writes per address"}, 128'(1), 128'(wr_hits[addr]));
        end

        status_line = dst_mem[status];
        check_value({name, " status done bit"}, 128'(1), 128'(status_line[0]));
        check_value({name, " status read field"}, 128'(lines), 128'(status_line[63:32]));
        check_value({name, " status resp field"}, 128'(lines), 128'(status_line[95:64]));
        check_value({name, " status cycle nonzero"}, 128'(1),
                    128'(status_line[127:96] != '0));
        csr_read(CSR_WRITE_REQ_CNT, rd_val);
        check_value({name, " write request count"}, 128'(lines), 128'(rd_val));
        csr_read(CSR_READ_IDX, rd_val);
        check_value({name, " read index"}, 128'(lines), 128'(rd_val));
        csr_read(CSR_WRITE_RESP_CNT, rd_val);
        check_value({name, " write response count"}, 128'(lines), 128'(rd_val));
        csr_read(CSR_CLK_CNT, rd_val);
        check_value({name, " cycle count nonzero"}, 128'(1), 128'(rd_val != '0));
        csr_read(CSR_STATE, rd_val);
        check_value({name, " state after job"}, 128'(CTRL_IDLE), 128'(rd_val));
    endtask

    // ======================================================================
    // clock, host model and test sequence
    // ======================================================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        rd_req_almost_full = 1'b0;
        wr_req_almost_full = 1'b0;
        rd_rsp_valid       = 1'b0;
        rd_rsp_tag         = '0;
        rd_rsp_data        = '0;
        wr_rsp_valid       = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            model_cycle();
        end
    end

    initial
    begin
        t_csr_data rd_val;
        int        lines;
        csr_wr_en   = 1'b0;
        csr_wr_addr = '0;
        csr_wr_data = '0;
        csr_rd_addr = '0;
        reset       = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // idle after reset, a zero-line start is ignored
        csr_read(CSR_STATE, rd_val);
        check_value("reset state", 128'(CTRL_IDLE), 128'(rd_val));
        csr_write(CSR_SRC_ADDR, 64'h100);
        csr_write(CSR_DST_ADDR, 64'h200);
        csr_write(CSR_NUM_LINES, 64'd0);
        csr_write(CSR_CTL, 64'd1);
        repeat (20)
        begin
            @(posedge clk);
            #2;
            check_value("idle rd_req_valid", 128'(0), 128'(rd_req_valid));
            check_value("idle wr_req_valid", 128'(0), 128'(wr_req_valid));
        end
        check_value("zero-line start reads", 128'(0), 128'(pend_tag.size()));
        csr_read(CSR_STATE, rd_val);
        check_value("zero-line start state", 128'(CTRL_IDLE), 128'(rd_val));

        // CSR readback
        csr_write(CSR_STATUS_ADDR, 64'h0000_5a5a);
        csr_write(CSR_SRC_ADDR, 64'h0001_2345);
        csr_write(CSR_DST_ADDR, 64'h0006_789a);
        csr_write(CSR_NUM_LINES, 64'd33);
        csr_read(CSR_STATUS_ADDR, rd_val);
        check_value("status addr readback", 128'(64'h0000_5a5a), 128'(rd_val));
        csr_read(CSR_SRC_ADDR, rd_val);
        check_value("src addr readback", 128'(64'h0001_2345), 128'(rd_val));
        csr_read(CSR_DST_ADDR, rd_val);
        check_value("dst addr readback", 128'(64'h0006_789a), 128'(rd_val));
        csr_read(CSR_NUM_LINES, rd_val);
        check_value("num lines readback", 128'(33), 128'(rd_val));
        csr_read(CSR_CTL, rd_val);
        check_value("ctl reads zero", 128'(0), 128'(rd_val));
        csr_read(4'hf, rd_val);
        check_value("unmapped reads zero", 128'(0), 128'(rd_val));

        lines = 20 + int'(random_bits(6)) % 41;
        run_job("job one", 32'h0000_1000, 32'h0000_4000, 32'h0000_8000, lines);
        lines = 20 + int'(random_bits(6)) % 41;
        run_job("job two", 32'h0003_0000, 32'h0006_0000, 32'h0009_0000, lines);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
